// ==== src/afifo_macros.svh ====
// async FIFO sizing and read output register switch
// shared by package, RTL and testbench

`ifndef AFIFO_MACROS_SVH
`define AFIFO_MACROS_SVH

// ####################
// data path
// ####################
`define AFIFO_DW     32    // data word width

// ####################
// depth and pointers
// ####################
`define AFIFO_DEPTH  16    // number of words, power of two
`define AFIFO_AW     4     // log2 of depth, pointers carry one extra wrap bit

// ####################
// memory read port
// ####################
`define AFIFO_RD_REG 1     // 1 = registered rd_dout, 0 = direct from array

`endif

// ==== src/afifo_pkg.sv ====
// pointer and write status structs for the async FIFO

`default_nettype none

`include "afifo_macros.svh"

package afifo_pkg;

    // ####################
    // pointer pair
    // ####################
    // binary for addressing and counting, gray for the domain crossing
    typedef struct packed {
        logic [`AFIFO_AW:0] bin;   // msb is the wrap bit
        logic [`AFIFO_AW:0] gray;  // gray copy of bin
    } ptr_t;

    // ####################
    // write side status
    // ####################
    typedef struct packed {
        logic               full;   // no room for another word
        logic [`AFIFO_AW:0] count;  // words held, seen from wr_clk
    } wr_status_t;

endpackage

`default_nettype wire

// ==== src/afifo_mem_dp.sv ====
// dual ported word memory, write on wr_clk, read on rd_clk
// read data registered or taken straight from the array

`timescale 1ns/1ps
`default_nettype none

module afifo_mem_dp #(
    parameter int DW    = 32,  // word width
    parameter int DEPTH = 16,  // words
    parameter int REG   = 1    // 1 = output register on rd_clk
) (
    input  wire                     wr_clk,   // write clock
    input  wire                     wr_en,    // write strobe
    input  wire [$clog2(DEPTH)-1:0] wr_addr,  // write address
    input  wire [DW-1:0]            wr_din,   // write data
    input  wire                     rd_clk,   // read clock
    input  wire                     rd_en,    // loads output register
    input  wire [$clog2(DEPTH)-1:0] rd_addr,  // read address
    output logic [DW-1:0]           rd_dout   // read data
);

    localparam int AW = $clog2(DEPTH);

    logic [DW-1:0] ram [0:DEPTH-1];  // storage, no reset
    logic [DW-1:0] rdata;            // async array read

    // ####################
    // write port
    // ####################
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            ram[wr_addr] <= wr_din;  // whole word, no mask
        end
    end

    assign rdata = ram[rd_addr[AW-1:0]];  // combinational read

    // ####################
    // read output
    // ####################
    generate
        if (REG == 1) begin : g_rd_reg
            logic [DW-1:0] rd_reg;  // holds until next accepted read
            always_ff @(posedge rd_clk) begin
                if (rd_en) begin
                    rd_reg <= rdata;
                end
            end
            assign rd_dout = rd_reg;
        end else begin : g_rd_direct
            assign rd_dout = rdata;  // head word shown directly
        end
    endgenerate

endmodule

`default_nettype wire

// ==== src/afifo_ptr_sync.sv ====
// two flop synchronizer for a gray coded pointer

`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_ptr_sync (
    input  wire                clk,      // destination domain clock
    input  wire                rst,      // sync reset, active high
    input  wire [`AFIFO_AW:0]  ptr_in,   // gray pointer from other domain
    output logic [`AFIFO_AW:0] ptr_out   // gray pointer, now in clk domain
);

    logic [`AFIFO_AW:0] stage1;  // first flop, may go metastable

    // ####################
    // sync chain
    // ####################
    // only one bit moves per step, so a late sample is just old or new
    always_ff @(posedge clk) begin
        if (rst) begin
            stage1  <= '0;
            ptr_out <= '0;
        end else begin
            stage1  <= ptr_in;   // capture
            ptr_out <= stage1;   // settle
        end
    end

endmodule

`default_nettype wire

// ==== src/afifo_wr_ctrl.sv ====
// write pointer, gray conversion, full flag and fill count on wr_clk

`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_wr_ctrl (
    input  wire                      wr_clk,        // write clock
    input  wire                      rst,           // sync reset, active high
    input  wire                      wr_en,         // write request
    input  wire [`AFIFO_AW:0]        rd_gray_sync,  // read pointer, synced
    output logic                     mem_we,        // accepted write
    output logic [`AFIFO_AW-1:0]     mem_waddr,     // write address
    output logic [`AFIFO_AW:0]       wr_gray,       // to the read domain
    output afifo_pkg::wr_status_t    status         // full and count
);

    afifo_pkg::ptr_t    wr_ptr;       // current write pointer
    afifo_pkg::ptr_t    wr_ptr_nxt;   // pointer after this edge
    logic               full_nxt;
    logic [`AFIFO_AW:0] rd_bin_sync;  // synced read pointer, binary
    logic [`AFIFO_AW:0] rd_full_cmp;  // read gray with two top bits flipped

    // ####################
    // next pointer
    // ####################
    assign mem_we    = wr_en & ~status.full;       // drop writes while full
    assign mem_waddr = wr_ptr.bin[`AFIFO_AW-1:0];  // wrap bit dropped
    assign wr_gray   = wr_ptr.gray;

    always_comb begin
        wr_ptr_nxt.bin  = wr_ptr.bin + {{`AFIFO_AW{1'b0}}, mem_we};
        wr_ptr_nxt.gray = (wr_ptr_nxt.bin >> 1) ^ wr_ptr_nxt.bin;  // bin to gray
    end

    // full when write is one lap ahead of read
    assign rd_full_cmp = {~rd_gray_sync[`AFIFO_AW:`AFIFO_AW-1],
                          rd_gray_sync[`AFIFO_AW-2:0]};
    assign full_nxt    = (wr_ptr_nxt.gray == rd_full_cmp);

    // gray to binary, msb first
    always_comb begin
        rd_bin_sync[`AFIFO_AW] = rd_gray_sync[`AFIFO_AW];
        for (int i = `AFIFO_AW - 1; i >= 0; i--) begin
            rd_bin_sync[i] = rd_bin_sync[i+1] ^ rd_gray_sync[i];
        end
    end

    // ####################
    // registers
    // ####################
    always_ff @(posedge wr_clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            status.full  <= 1'b0;
            status.count <= '0;
        end else begin
            wr_ptr       <= wr_ptr_nxt;
            status.full  <= full_nxt;                   // same edge as the write
            status.count <= wr_ptr_nxt.bin - rd_bin_sync;  // lags reads, safe side
        end
    end

endmodule

`default_nettype wire

// ==== src/afifo_rd_ctrl.sv ====
// read pointer, gray conversion, empty flag and memory read enable on rd_clk

`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_rd_ctrl (
    input  wire                  rd_clk,        // read clock
    input  wire                  rst,           // sync reset, active high
    input  wire                  rd_en,         // read request
    input  wire [`AFIFO_AW:0]    wr_gray_sync,  // write pointer, synced
    output logic                 mem_re,        // accepted read
    output logic [`AFIFO_AW-1:0] mem_raddr,     // read address
    output logic [`AFIFO_AW:0]   rd_gray,       // to the write domain
    output logic                 empty          // nothing to read
);

    afifo_pkg::ptr_t rd_ptr;      // current read pointer
    afifo_pkg::ptr_t rd_ptr_nxt;  // pointer after this edge
    logic            empty_nxt;

    // ####################
    // next pointer
    // ####################
    assign mem_re    = rd_en & ~empty;             // drop reads while empty
    assign mem_raddr = rd_ptr.bin[`AFIFO_AW-1:0];  // head word
    assign rd_gray   = rd_ptr.gray;

    always_comb begin
        rd_ptr_nxt.bin  = rd_ptr.bin + {{`AFIFO_AW{1'b0}}, mem_re};
        rd_ptr_nxt.gray = (rd_ptr_nxt.bin >> 1) ^ rd_ptr_nxt.bin;  // bin to gray
    end

    // empty when read catches the synced write pointer
    assign empty_nxt = (rd_ptr_nxt.gray == wr_gray_sync);

    // ####################
    // registers
    // ####################
    always_ff @(posedge rd_clk) begin
        if (rst) begin
            rd_ptr <= '0;
            empty  <= 1'b1;       // starts empty
        end else begin
            rd_ptr <= rd_ptr_nxt;
            empty  <= empty_nxt;  // synced writes show up late, safe side
        end
    end

endmodule

`default_nettype wire

// ==== src/afifo_top.sv ====
// async FIFO top level
// memory, write and read controllers, pointer synchronizers

`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_top (
    input  wire                   wr_clk,   // write clock
    input  wire                   rd_clk,   // read clock
    input  wire                   rst,      // sync reset, both domains
    input  wire                   wr_en,    // write strobe
    input  wire [`AFIFO_DW-1:0]   wr_din,   // write data
    input  wire                   rd_en,    // read strobe
    output logic [`AFIFO_DW-1:0]  rd_dout,  // read data
    output logic                  empty,    // read side flag
    output afifo_pkg::wr_status_t status    // write side full and count
);

    logic                 mem_we;
    logic [`AFIFO_AW-1:0] mem_waddr;
    logic                 mem_re;
    logic [`AFIFO_AW-1:0] mem_raddr;
    logic [`AFIFO_AW:0]   wr_gray;       // wr_clk domain
    logic [`AFIFO_AW:0]   rd_gray;       // rd_clk domain
    logic [`AFIFO_AW:0]   wr_gray_sync;  // write pointer in rd_clk domain
    logic [`AFIFO_AW:0]   rd_gray_sync;  // read pointer in wr_clk domain

    // ####################
    // write side
    // ####################
    afifo_wr_ctrl u_wr_ctrl (
        .wr_clk       (wr_clk),
        .rst          (rst),
        .wr_en        (wr_en),
        .rd_gray_sync (rd_gray_sync),
        .mem_we       (mem_we),
        .mem_waddr    (mem_waddr),
        .wr_gray      (wr_gray),
        .status       (status)
    );

    afifo_ptr_sync u_rd2wr_sync (  // read pointer into wr_clk
        .clk     (wr_clk),
        .rst     (rst),
        .ptr_in  (rd_gray),
        .ptr_out (rd_gray_sync)
    );

    // ####################
    // read side
    // ####################
    afifo_rd_ctrl u_rd_ctrl (
        .rd_clk       (rd_clk),
        .rst          (rst),
        .rd_en        (rd_en),
        .wr_gray_sync (wr_gray_sync),
        .mem_re       (mem_re),
        .mem_raddr    (mem_raddr),
        .rd_gray      (rd_gray),
        .empty        (empty)
    );

    afifo_ptr_sync u_wr2rd_sync (  // write pointer into rd_clk
        .clk     (rd_clk),
        .rst     (rst),
        .ptr_in  (wr_gray),
        .ptr_out (wr_gray_sync)
    );

    // ####################
    // storage
    // ####################
    afifo_mem_dp #(
        .DW    (`AFIFO_DW),
        .DEPTH (`AFIFO_DEPTH),
        .REG   (`AFIFO_RD_REG)
    ) u_mem (
        .wr_clk  (wr_clk),
        .wr_en   (mem_we),
        .wr_addr (mem_waddr),
        .wr_din  (wr_din),
        .rd_clk  (rd_clk),
        .rd_en   (mem_re),
        .rd_addr (mem_raddr),
        .rd_dout (rd_dout)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// free running clock source for the testbench

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter realtime PERIOD = 100.0  // ns
) (
    output logic clk  // starts low
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;  // even duty cycle
    end

endmodule

`default_nettype wire

// ==== verif/afifo_asserts.sv ====
// pointer and flag properties for the async FIFO
// bound into afifo_top

`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_asserts (
    input wire                        wr_clk,
    input wire                        rd_clk,
    input wire                        rst,
    input wire                        empty,    // read side flag
    input wire [`AFIFO_AW:0]          wr_gray,  // write pointer, wr_clk domain
    input wire [`AFIFO_AW:0]          rd_gray,  // read pointer, rd_clk domain
    input wire afifo_pkg::wr_status_t status    // full and count
);

    int fail_cnt = 0;  // read by the testbench at the end

    // ####################
    // back-pressure
    // ####################
    a_wr_hold_full : assert property (
        @(posedge wr_clk) disable iff (rst) status.full |=> $stable(wr_gray)
    ) else begin
        fail_cnt++;
        $error("write pointer moved while full");
    end

    a_rd_hold_empty : assert property (
        @(posedge rd_clk) disable iff (rst) empty |=> $stable(rd_gray)
    ) else begin
        fail_cnt++;
        $error("read pointer moved while empty");
    end

    // ####################
    // flag exclusion
    // ####################
    // equal pointers mean nothing stored, so full must be low there
    a_flags_excl : assert property (
        @(posedge rd_clk) disable iff (rst)
            !(status.full && empty && (wr_gray == rd_gray))
    ) else begin
        fail_cnt++;
        $error("full and empty high together on equal pointers");
    end

endmodule

bind afifo_top afifo_asserts u_asserts (
    .wr_clk  (wr_clk),
    .rd_clk  (rd_clk),
    .rst     (rst),
    .empty   (empty),
    .wr_gray (wr_gray),
    .rd_gray (rd_gray),
    .status  (status)
);

`default_nettype wire

// ==== verif/tb_afifo.sv ====
// async FIFO testbench with clocks, stimulus, queue model, read compare
// and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module tb_afifo;

    localparam int     DW         = `AFIFO_DW;
    localparam int     DEPTH      = `AFIFO_DEPTH;
    localparam int     RAND_OPS   = 400;                       // random burst length
    localparam int     NUM_OPS    = RAND_OPS + 4 * DEPTH + 16;  // burst plus directed part
    localparam longint TIMEOUT_NS = NUM_OPS * 100 * 8;
    localparam int     WAIT_LIMIT = 64;                        // rd_clk cycles per flag wait

    wire                   wr_clk;
    wire                   rd_clk;
    logic                  rst;
    logic                  wr_en;
    logic [DW-1:0]         wr_din;
    logic                  rd_en;
    wire  [DW-1:0]         rd_dout;
    wire                   empty;
    afifo_pkg::wr_status_t status;

    logic [DW-1:0] model_q [$];  // words the DUT accepted, oldest first
    int            wr_count;     // accepted writes
    int            rd_count;     // accepted reads
    logic [DW-1:0] saved_dout;

    tb_clk_gen #(.PERIOD(100.0)) u_rd_clk_gen (.clk(rd_clk));
    tb_clk_gen #(.PERIOD(70.0))  u_wr_clk_gen (.clk(wr_clk));  // no common ratio

    afifo_top u_dut (
        .wr_clk  (wr_clk),
        .rd_clk  (rd_clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_din  (wr_din),
        .rd_en   (rd_en),
        .rd_dout (rd_dout),
        .empty   (empty),
        .status  (status)
    );

    // ####################
    // helpers
    // ####################
    task automatic abort_run(input string why);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_val(input logic [DW-1:0] actual, input logic [DW-1:0] expected,
                             input string msg);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got 0x%h, expected 0x%h",
                     $time, msg, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    function automatic logic [DW-1:0] expected_word();
        return model_q.pop_front();  // oldest word goes out first
    endfunction

    task automatic write_cycle(input logic en);
        @(negedge wr_clk);
        wr_en  = en;
        wr_din = $urandom;
        if (en && !status.full) begin  // full is stable until the next edge
            model_q.push_back(wr_din);
            wr_count++;
        end
        check_val(status.count <= DEPTH, 1, "fill count above depth");
    endtask

    task automatic read_cycle(input logic en);
        @(negedge rd_clk);
        rd_en = en;
        if (en && !empty) begin
            rd_count++;
        end
    endtask

    task automatic fill_words(input int n);
        int target;
        target = wr_count + n;
        for (int tries = 0; wr_count < target; tries++) begin
            if (tries > n * 4 + WAIT_LIMIT) abort_run("writes were never accepted");
            write_cycle(1'b1);
        end
    endtask

    task automatic read_words(input int n);
        int target;
        target = rd_count + n;
        for (int tries = 0; rd_count < target; tries++) begin
            if (tries > n * 8 + WAIT_LIMIT) abort_run("reads were never accepted");
            read_cycle(1'b1);
        end
        read_cycle(1'b0);
    endtask

    task automatic wait_empty();
        for (int tries = 0; !empty; tries++) begin
            if (tries == WAIT_LIMIT) abort_run("empty never rose after the drain");
            @(negedge rd_clk);
        end
    endtask

    // ####################
    // read compare
    // ####################
    initial begin : compare_reads
        forever begin
            @(posedge rd_clk);
            if (rd_en && !empty) begin          // accepted at this edge
                if (`AFIFO_RD_REG == 1) @(negedge rd_clk);  // output register loaded
                if (model_q.size() == 0) abort_run("read returned a word never written");
                check_val(rd_dout, expected_word(), "read data");
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        abort_run("timeout, the run did not finish in time");
    end

    // ####################
    // stimulus
    // ####################
    initial begin : main_seq
        void'($urandom(91));
        rst      = 1'b1;
        wr_en    = 1'b0;
        wr_din   = '0;
        rd_en    = 1'b0;
        wr_count = 0;
        rd_count = 0;
        repeat (5) @(posedge rd_clk);
        @(negedge rd_clk);
        rst = 1'b0;  // about 7 wr_clk edges seen in reset
        check_val(empty, 1, "empty after reset");
        check_val(status.full, 0, "full after reset");
        check_val(status.count, 0, "count after reset");

        fill_words(DEPTH);                      // no reads so full at DEPTH
        repeat (4) write_cycle(1'b1);           // dropped while full
        write_cycle(1'b0);
        check_val(status.full, 1, "full after depth writes");
        check_val(wr_count, DEPTH, "writes accepted while full");

        read_words(DEPTH);                      // in-order read back
        wait_empty();
        @(negedge rd_clk);                      // last compare done
        check_val(model_q.size(), 0, "model words left after drain");
        saved_dout = rd_dout;
        repeat (4) read_cycle(1'b1);            // dropped while empty
        read_cycle(1'b0);
        check_val(rd_dout, saved_dout, "rd_dout after reads while empty");
        check_val(rd_count, wr_count, "reads accepted while empty");
        repeat (5) @(negedge wr_clk);           // full falls within 4 edges
        check_val(status.full, 0, "full after drain");
        check_val(status.count, 0, "count after drain");

        fork
            begin
                repeat (RAND_OPS) write_cycle(1'($urandom));
                write_cycle(1'b0);              // write side idle while reads go on
            end
            repeat (RAND_OPS) read_cycle(1'($urandom));
        join
        read_words(wr_count - rd_count);        // drain what is left
        wait_empty();
        @(negedge rd_clk);
        check_val(model_q.size(), 0, "model words left after burst");

        if (u_dut.u_asserts.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("bound assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/afifo_pkg.sv
src/afifo_mem_dp.sv
src/afifo_ptr_sync.sv
src/afifo_wr_ctrl.sv
src/afifo_rd_ctrl.sv
src/afifo_top.sv
verif/tb_clk_gen.sv
verif/afifo_asserts.sv
verif/tb_afifo.sv
